//--- project.f
+incdir+hdl
hdl/dataPathPkg.sv
hdl/busArbiter.sv
hdl/registerFile.sv
hdl/specialRegs.sv
hdl/aluUnit.sv
hdl/memoryUnit.sv
hdl/dataPath.sv
test/dataPathTb.sv

//--- test/dataPathTb.sv
// Directed tests that drive every strobe by hand; stops at the first mismatch, fixed LFSR seed
`include "datapath_params.svh"

module dataPathTb;
   timeunit 1ns;
   timeprecision 10ps;

   localparam int ClkPeriod = 40;
   localparam int Pairs = 20;
   // Rough cycle budget of all tests, doubled for the watchdog
   localparam int TestCycles = 16 + 64 + 3 * 40 + Pairs * 6 * 7 + 60 + 60;
   localparam int TimeoutNs = 2 * TestCycles * ClkPeriod;

   logic                Clock = 1'b0;
   logic                rst;
   logic                start;
   logic                finished;
   logic                memFinished;
   logic                branch;
   logic [3:0]          rfSelect;
   logic [`WORD_W-1:0]  extData;
   logic [`WORD_W-1:0]  busValue;
   dataPathPkg::ctrl_t  ctrl;
   dataPathPkg::aluOp_t opSelect;
   // Expected contents of the general registers
   logic [`WORD_W-1:0]  regModel [`REG_COUNT];
   logic [31:0]         lfsrState = 32'he6bfd217;

   dataPath u_dataPath (
      .Clock, .rst, .ctrl, .rfSelect, .opSelect, .start, .extData,
      .busValue, .finished, .memFinished, .branch
   );

   always #(ClkPeriod / 2) Clock = ~Clock;

   // Taps 32, 22, 2, 1
   function automatic logic lfsrBit();
      logic fb;
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      return fb;
   endfunction

   function automatic logic [`WORD_W-1:0] randWord();
      logic [`WORD_W-1:0] w;
      w = '0;
      for (int i = 0; i < `WORD_W; i++) begin
         w = {w[`WORD_W-2:0], lfsrBit()};
      end
      return w;
   endfunction

   task automatic failRun(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "run stopped");
   endtask

   task automatic checkWord(input string name, input logic [`WORD_W-1:0] got, exp);
      if (got !== exp) begin
         failRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic checkFlag(input string name, input logic got, exp);
      if (got !== exp) begin
         failRun($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   task automatic checkInstr(input string name, input dataPathPkg::instr_u got, exp);
      if (got !== exp) begin
         failRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   // One cycle of drive, then every strobe drops
   task automatic tick();
      @(negedge Clock);
      ctrl = '0;
      start = 1'b0;
   endtask

   // Drive a bus source for one cycle and sample the bus mid-cycle
   task automatic sampleBus(input dataPathPkg::ctrl_t src, input logic [3:0] sel,
                            output logic [`WORD_W-1:0] v);
      ctrl = src;
      rfSelect = sel;
      #5;
      v = busValue;
      tick();
   endtask

   task automatic loadExt(input dataPathPkg::ctrl_t loads, input logic [`WORD_W-1:0] v);
      ctrl = loads;
      ctrl.extOut = 1'b1;
      extData = v;
      tick();
   endtask

   task automatic waitPulse(input logic useMem, input int bound, input string what);
      int n;
      n = 0;
      while (!(useMem ? memFinished : finished)) begin
         if (n >= bound) failRun($sformatf("%s did not arrive within %0d cycles", what, bound));
         @(negedge Clock);
         n++;
      end
   endtask

   task automatic testRegisters();
      dataPathPkg::ctrl_t c;
      logic [`WORD_W-1:0] v;
      c = '0;
      c.rfIn = 1'b1;
      for (int i = 0; i < `REG_COUNT; i++) begin
         regModel[i] = randWord();
         rfSelect = i[3:0];
         loadExt(c, regModel[i]);
      end
      c = '0;
      c.rfOut = 1'b1;
      for (int i = 0; i < `REG_COUNT; i++) begin
         sampleBus(c, i[3:0], v);
         checkWord($sformatf("busValue R%0d", i), v, regModel[i]);
      end
      sampleBus('0, 4'd0, v);
      checkWord("busValue idle", v, '0);
   endtask

   // Store an addi word, fetch it from RAM and execute it by hand
   task automatic addiRun(input logic [`WORD_W-1:0] addr, input logic [3:0] ra, rb,
                          input logic [18:0] imm);
      dataPathPkg::instr_u w;
      dataPathPkg::ctrl_t  c;
      logic [`WORD_W-1:0]  v;
      logic [`WORD_W-1:0]  expVal;
      w = '0;
      w.iFmt.opcode = dataPathPkg::OP_ADD;
      w.iFmt.ra = ra;
      w.iFmt.rb = rb;
      w.iFmt.imm = imm;
      c = '0;
      c.marIn = 1'b1;
      loadExt(c, addr);
      c = '0;
      c.mdrIn = 1'b1;
      loadExt(c, w);
      ctrl.write = 1'b1;
      tick();
      waitPulse(1'b1, `MEM_LATENCY + 2, "memFinished after write");
      c = '0;
      c.pcIn = 1'b1;
      loadExt(c, addr);
      ctrl.pcOut = 1'b1;
      ctrl.marIn = 1'b1;
      tick();
      // MDR must stay loadable until the read completes
      ctrl.read = 1'b1;
      ctrl.mdrIn = 1'b1;
      tick();
      ctrl.mdrIn = 1'b1;
      waitPulse(1'b1, `MEM_LATENCY + 2, "memFinished after read");
      ctrl = '0;
      ctrl.mdrOut = 1'b1;
      ctrl.irIn = 1'b1;
      tick();
      c = '0;
      c.irOut = 1'b1;
      sampleBus(c, 4'd0, v);
      checkInstr("busValue IR", v, w);
      ctrl.grb = 1'b1;
      ctrl.baOut = 1'b1;
      ctrl.rout = 1'b1;
      ctrl.ryIn = 1'b1;
      tick();
      ctrl.immOut = 1'b1;
      ctrl.rzIn = 1'b1;
      opSelect = dataPathPkg::OP_ADD;
      start = 1'b1;
      tick();
      waitPulse(1'b0, 4, "finished after addi");
      ctrl.rzLoOut = 1'b1;
      ctrl.gra = 1'b1;
      ctrl.rin = 1'b1;
      tick();
      // R0 is a zero base on the BAout path
      expVal = ((rb == 4'd0) ? '0 : regModel[rb]) + `WORD_W'($signed(imm));
      regModel[ra] = expVal;
      c = '0;
      c.rfOut = 1'b1;
      sampleBus(c, ra, v);
      checkWord($sformatf("busValue R%0d", ra), v, expVal);
   endtask

   function automatic logic [`WORD_W-1:0] aluExpect(input dataPathPkg::aluOp_t op,
                                                   input logic [`WORD_W-1:0] a, b);
      case (op)
         dataPathPkg::OP_ADD: return a + b;
         dataPathPkg::OP_SUB: return a - b;
         dataPathPkg::OP_AND: return a & b;
         dataPathPkg::OP_OR:  return a | b;
         dataPathPkg::OP_SHL: return a << b[4:0];
         default:             return a >> b[4:0];
      endcase
   endfunction

   task automatic testAlu();
      dataPathPkg::aluOp_t ops [6];
      dataPathPkg::ctrl_t  c;
      logic [`WORD_W-1:0]  a, b, v;
      ops = '{dataPathPkg::OP_ADD, dataPathPkg::OP_SUB, dataPathPkg::OP_AND,
              dataPathPkg::OP_OR, dataPathPkg::OP_SHL, dataPathPkg::OP_SHR};
      c = '0;
      c.rzLoOut = 1'b1;
      for (int p = 0; p < Pairs; p++) begin
         a = randWord();
         b = randWord();
         foreach (ops[k]) begin
            ctrl.ryIn = 1'b1;
            loadExt(ctrl, a);
            ctrl.rzIn = 1'b1;
            opSelect = ops[k];
            start = 1'b1;
            loadExt(ctrl, b);
            waitPulse(1'b0, 4, $sformatf("finished after %s", ops[k].name()));
            sampleBus(c, 4'd0, v);
            checkWord($sformatf("RZ low %s", ops[k].name()), v, aluExpect(ops[k], a, b));
         end
      end
   endtask

   task automatic testMultiply();
      dataPathPkg::ctrl_t     c;
      logic [`WORD_W-1:0]     a, b, v;
      logic [2*`WORD_W-1:0]   prod;
      a = randWord();
      b = randWord();
      prod = {{`WORD_W{1'b0}}, a} * {{`WORD_W{1'b0}}, b};
      ctrl.ryIn = 1'b1;
      loadExt(ctrl, a);
      opSelect = dataPathPkg::OP_MUL;
      start = 1'b1;
      loadExt(ctrl, b);
      waitPulse(1'b0, `WORD_W + 4, "finished after multiply");
      ctrl.rzHiOut = 1'b1;
      ctrl.hiIn = 1'b1;
      tick();
      ctrl.rzLoOut = 1'b1;
      ctrl.loIn = 1'b1;
      tick();
      c = '0;
      c.hiOut = 1'b1;
      sampleBus(c, 4'd0, v);
      checkWord("busValue HI", v, prod[2*`WORD_W-1:`WORD_W]);
      c = '0;
      c.loOut = 1'b1;
      sampleBus(c, 4'd0, v);
      checkWord("busValue LO", v, prod[`WORD_W-1:0]);
   endtask

   task automatic testBranch();
      dataPathPkg::instr_u w;
      dataPathPkg::ctrl_t  c;
      logic [`WORD_W-1:0]  vals [3];
      logic [`WORD_W-1:0]  p, v;
      logic                exp;
      // Zero, then a positive and a negative bus value
      vals[0] = '0;
      vals[1] = (randWord() & 32'h7fff_ffff) | 32'h1;
      vals[2] = randWord() | 32'h8000_0000;
      for (int cond = 0; cond < 4; cond++) begin
         w = '0;
         w.iFmt.rb = cond[3:0];
         ctrl.irIn = 1'b1;
         loadExt(ctrl, w);
         foreach (vals[k]) begin
            case (cond)
               0:       exp = (k == 0);
               1:       exp = (k != 0);
               2:       exp = (k == 1);
               default: exp = (k == 2);
            endcase
            ctrl.conffIn = 1'b1;
            loadExt(ctrl, vals[k]);
            checkFlag($sformatf("branch cond %0d", cond), branch, exp);
         end
      end
      p = randWord();
      ctrl.pcIn = 1'b1;
      loadExt(ctrl, p);
      ctrl.incPc = 1'b1;
      tick();
      c = '0;
      c.pcOut = 1'b1;
      sampleBus(c, 4'd0, v);
      checkWord("busValue PC", v, p + 1'b1);
   endtask

   initial begin
      rst = 1'b1;
      ctrl = '0;
      start = 1'b0;
      rfSelect = '0;
      opSelect = dataPathPkg::OP_ADD;
      extData = '0;
      repeat (16) @(negedge Clock);
      rst = 1'b0;
      testRegisters();
      addiRun(32'd10, 4'd7, 4'd3, 19'h00123);
      // Immediate of -300
      addiRun(32'd20, 4'd9, 4'd5, 19'h7fed4);
      addiRun(32'd30, 4'd11, 4'd0, 19'h01f0f);
      testAlu();
      testMultiply();
      testBranch();
      $display("*** TEST PASSED ***");
      $finish;
   end

   initial begin
      #(TimeoutNs);
      failRun("watchdog expired before the tests completed");
   end

endmodule

//--- hdl/dataPath.sv
// Top level with no registers of its own; peer latencies hold unchanged at these ports
`include "datapath_params.svh"

module dataPath (
   input  logic                   Clock,
   input  logic                   rst,
   input  dataPathPkg::ctrl_t     ctrl,
   input  logic [3:0]             rfSelect,
   input  dataPathPkg::aluOp_t    opSelect,
   input  logic                   start,
   input  logic [`WORD_W-1:0]     extData,
   output logic [`WORD_W-1:0]     busValue,
   output logic                   finished,
   output logic                   memFinished,
   output logic                   branch
);

   dataPathPkg::busReq_t busReq;
   dataPathPkg::instr_u  instr;
   logic [`WORD_W-1:0]   rfData, pcData, irData, hiData, loData, immData;
   logic [`WORD_W-1:0]   ryData, rzLoData, rzHiData, marData, mdrData;

   // Priority order, register file first and external port last
   assign busReq.req = {ctrl.extOut, ctrl.mdrOut, ctrl.immOut, ctrl.loOut,
                        ctrl.hiOut, ctrl.marOut, ctrl.rzHiOut, ctrl.rzLoOut,
                        ctrl.ryOut, ctrl.irOut, ctrl.pcOut, ctrl.rfOut | ctrl.rout};
   assign busReq.data = {extData, mdrData, immData, loData,
                         hiData, marData, rzHiData, rzLoData,
                         ryData, irData, pcData, rfData};

   busArbiter u_busArbiter (.Clock, .rst, .req(busReq), .busValue);

   registerFile u_registerFile (.Clock, .rst, .ctrl, .rfSelect, .instr, .busValue, .rfData);

   specialRegs u_specialRegs (
      .Clock, .rst, .ctrl, .busValue, .instr,
      .pcData, .irData, .hiData, .loData, .immData, .branch
   );

   aluUnit u_aluUnit (
      .Clock, .rst, .ctrl, .opSelect, .start, .busValue,
      .ryData, .rzLoData, .rzHiData, .finished
   );

   memoryUnit u_memoryUnit (.Clock, .rst, .ctrl, .busValue, .marData, .mdrData, .memFinished);

endmodule

//--- hdl/memoryUnit.sv
// RAM addressed by low MAR bits, no RAM reset; strobes while a request is pending are dropped
`include "datapath_params.svh"

module memoryUnit (
   input  logic                   Clock,
   input  logic                   rst,
   input  dataPathPkg::ctrl_t     ctrl,
   input  logic [`WORD_W-1:0]     busValue,
   output logic [`WORD_W-1:0]     marData,
   output logic [`WORD_W-1:0]     mdrData,
   output logic                   memFinished
);

   localparam int AddrW = $clog2(`MEM_DEPTH);
   localparam int CntW  = $clog2(`MEM_LATENCY + 1);

   logic [`WORD_W-1:0] ram [`MEM_DEPTH];
   logic [AddrW-1:0]   addr;
   logic               busy;
   logic               isRead;
   logic               done;
   logic [CntW-1:0]    count;

   assign addr = marData[AddrW-1:0];
   // Last pending cycle, the access lands at the next edge
   assign done = busy && (count == '0);

   always_ff @(posedge Clock) begin
      if (rst) begin
         marData     <= '0;
         mdrData     <= '0;
         busy        <= 1'b0;
         isRead      <= 1'b0;
         count       <= '0;
         memFinished <= 1'b0;
      end else begin
         memFinished <= done;
         if (ctrl.marIn) marData <= busValue;
         if (ctrl.mdrIn) begin
            mdrData <= (done && isRead) ? ram[addr] : busValue;
         end
         if (done) begin
            busy <= 1'b0;
         end else if (busy) begin
            count <= count - 1'b1;
         end else if (ctrl.read || ctrl.write) begin
            busy   <= 1'b1;
            isRead <= ctrl.read;
            count  <= CntW'(`MEM_LATENCY - 2);
         end
      end
   end

   always_ff @(posedge Clock) begin
      if (done && !isRead) ram[addr] <= mdrData;
   end

endmodule

//--- hdl/aluUnit.sv
// Single-cycle ops write RZ only under rzIn; unsigned multiply takes 32 iterations and ignores rzIn
`include "datapath_params.svh"

module aluUnit (
   input  logic                   Clock,
   input  logic                   rst,
   input  dataPathPkg::ctrl_t     ctrl,
   input  dataPathPkg::aluOp_t    opSelect,
   input  logic                   start,
   input  logic [`WORD_W-1:0]     busValue,
   output logic [`WORD_W-1:0]     ryData,
   output logic [`WORD_W-1:0]     rzLoData,
   output logic [`WORD_W-1:0]     rzHiData,
   output logic                   finished
);

   localparam int CountW = $clog2(`WORD_W);

   logic [2*`WORD_W-1:0] rz;
   logic [`WORD_W-1:0]   result;
   logic                 startOne;
   logic                 startMul;
   // Shift-and-add multiplier state
   logic                 busy;
   logic [CountW-1:0]    iter;
   logic [2*`WORD_W-1:0] mcand;
   logic [`WORD_W-1:0]   mplier;

   assign startOne = start && !busy && (opSelect != dataPathPkg::OP_MUL);
   assign startMul = start && !busy && (opSelect == dataPathPkg::OP_MUL);

   always_comb begin
      case (opSelect)
         dataPathPkg::OP_ADD: result = ryData + busValue;
         dataPathPkg::OP_SUB: result = ryData - busValue;
         dataPathPkg::OP_AND: result = ryData & busValue;
         dataPathPkg::OP_OR:  result = ryData | busValue;
         dataPathPkg::OP_SHL: result = ryData << busValue[4:0];
         dataPathPkg::OP_SHR: result = ryData >> busValue[4:0];
         default:             result = '0;
      endcase
   end

   always_ff @(posedge Clock) begin
      if (rst) begin
         ryData   <= '0;
         rz       <= '0;
         busy     <= 1'b0;
         iter     <= '0;
         finished <= 1'b0;
      end else begin
         finished <= 1'b0;
         if (ctrl.ryIn) ryData <= busValue;
         if (startOne) begin
            finished <= 1'b1;
            if (ctrl.rzIn) rz <= {{`WORD_W{1'b0}}, result};
         end else if (startMul) begin
            busy <= 1'b1;
            iter <= '0;
            rz   <= '0;
         end else if (busy) begin
            // RZ is the product accumulator
            if (mplier[0]) rz <= rz + mcand;
            iter <= iter + 1'b1;
            if (iter == CountW'(`WORD_W - 1)) begin
               busy     <= 1'b0;
               finished <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge Clock) begin
      if (startMul) begin
         mcand  <= {{`WORD_W{1'b0}}, ryData};
         mplier <= busValue;
      end else if (busy) begin
         mcand  <= mcand << 1;
         mplier <= mplier >> 1;
      end
   end

   assign rzLoData = rz[`WORD_W-1:0];
   assign rzHiData = rz[2*`WORD_W-1:`WORD_W];

   finishedPulse : assert property (@(posedge Clock) disable iff (rst)
      finished |=> !finished)
      else $error("finished high two cycles in a row");

endmodule

//--- hdl/specialRegs.sv
// PC, IR, HI, LO and branch flag; immediate is the 19-bit iFmt field sign-extended to the word
`include "datapath_params.svh"

module specialRegs (
   input  logic                   Clock,
   input  logic                   rst,
   input  dataPathPkg::ctrl_t     ctrl,
   input  logic [`WORD_W-1:0]     busValue,
   output dataPathPkg::instr_u    instr,
   output logic [`WORD_W-1:0]     pcData,
   output logic [`WORD_W-1:0]     irData,
   output logic [`WORD_W-1:0]     hiData,
   output logic [`WORD_W-1:0]     loData,
   output logic [`WORD_W-1:0]     immData,
   output logic                   branch
);

   logic condMet;

   always_ff @(posedge Clock) begin
      if (rst) begin
         pcData <= '0;
         instr  <= '0;
         hiData <= '0;
         loData <= '0;
         branch <= 1'b0;
      end else begin
         if (ctrl.pcIn) begin
            pcData <= busValue;
         end else if (ctrl.incPc) begin
            pcData <= pcData + 1'b1;
         end
         if (ctrl.irIn) instr <= busValue;
         if (ctrl.hiIn) hiData <= busValue;
         if (ctrl.loIn) loData <= busValue;
         if (ctrl.conffIn) branch <= condMet;
      end
   end

   assign irData  = instr;
   assign immData = {{(`WORD_W - 19){instr.iFmt.imm[18]}}, instr.iFmt.imm};

   // Condition code 0 zero, 1 nonzero, 2 positive, 3 negative
   always_comb begin
      case (instr.iFmt.rb[1:0])
         2'd0:    condMet = (busValue == '0);
         2'd1:    condMet = (busValue != '0);
         2'd2:    condMet = !busValue[`WORD_W-1] && (busValue != '0);
         default: condMet = busValue[`WORD_W-1];
      endcase
   end

   // Load and increment of PC would race
   pcLoadOrInc : assert property (@(posedge Clock) disable iff (rst)
      !(ctrl.pcIn && ctrl.incPc))
      else $error("pcIn and incPc high together");

endmodule

//--- hdl/registerFile.sv
// Sixteen registers, asynchronous read; field select overrides rfSelect, R0 reads zero under baOut
`include "datapath_params.svh"

module registerFile (
   input  logic                   Clock,
   input  logic                   rst,
   input  dataPathPkg::ctrl_t     ctrl,
   input  logic [3:0]             rfSelect,
   input  dataPathPkg::instr_u    instr,
   input  logic [`WORD_W-1:0]     busValue,
   output logic [`WORD_W-1:0]     rfData
);

   logic [`WORD_W-1:0] regs [`REG_COUNT];
   logic [3:0]         sel;
   logic               writeEn;

   // Register index from the IR fields or the direct select
   always_comb begin
      if (ctrl.gra) begin
         sel = instr.rFmt.ra;
      end else if (ctrl.grb) begin
         sel = instr.rFmt.rb;
      end else if (ctrl.grc) begin
         sel = instr.rFmt.rc;
      end else begin
         sel = rfSelect;
      end
   end

   assign writeEn = ctrl.rfIn | ctrl.rin;

   always_ff @(posedge Clock) begin
      if (rst) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[sel] <= busValue;
      end
   end

   // Base address path treats R0 as a zero base
   assign rfData = (ctrl.baOut && sel == 4'd0) ? '0 : regs[sel];

   // Only one IR field may pick the register at a time
   fieldSelectOne : assert property (@(posedge Clock) disable iff (rst)
      $onehot0({ctrl.gra, ctrl.grb, ctrl.grc}))
      else $error("more than one of gra, grb, grc high");

endmodule

//--- hdl/busArbiter.sv
// Fixed priority with the lowest request index winning; the bus reads zero when nobody drives it
`include "datapath_params.svh"

module busArbiter (
   input  logic                   Clock,
   input  logic                   rst,
   input  dataPathPkg::busReq_t   req,
   output logic [`WORD_W-1:0]     busValue
);

   localparam int DrvCount = $size(req.req);

   logic [DrvCount-1:0] grant;

   // One-hot grant to the lowest requesting index
   always_comb begin
      grant = '0;
      for (int i = DrvCount - 1; i >= 0; i--) begin
         if (req.req[i]) begin
            grant = '0;
            grant[i] = 1'b1;
         end
      end
   end

   // AND-OR mux of the granted word, zero when idle
   always_comb begin
      busValue = '0;
      for (int i = 0; i < DrvCount; i++) begin
         busValue = busValue | (req.data[i] & {`WORD_W{grant[i]}});
      end
   end

   // Caller must never raise two drive strobes together
   busSingleDriver : assert property (@(posedge Clock) disable iff (rst)
      $onehot0(req.req))
      else $error("bus conflict, requests %b", req.req);

endmodule

//--- hdl/dataPathPkg.sv
// Shared types for the single-bus datapath; the instruction word layout assumes a 32-bit word
`include "datapath_params.svh"

package dataPathPkg;

   // Every strobe the caller drives, one bit each
   typedef struct packed {
      // Bus drivers
      logic rfOut, pcOut, irOut, ryOut, rzLoOut, rzHiOut;
      logic marOut, hiOut, loOut, immOut, mdrOut, extOut;
      // Register loads
      logic rfIn, pcIn, irIn, ryIn, rzIn;
      logic marIn, hiIn, loIn, mdrIn, conffIn;
      // Instruction-field register selection
      logic gra, grb, grc, baOut, rout, rin;
      // Memory and PC
      logic read, write, incPc;
   } ctrl_t;

   // Register format: opcode, ra, rb, rc
   typedef struct packed {
      logic [4:0]  opcode;
      logic [3:0]  ra;
      logic [3:0]  rb;
      logic [3:0]  rc;
      logic [14:0] unused;
   } rFmt_t;

   // Immediate format, branch condition sits in rb[1:0]
   typedef struct packed {
      logic [4:0]  opcode;
      logic [3:0]  ra;
      logic [3:0]  rb;
      logic [18:0] imm;
   } iFmt_t;

   typedef union packed {
      rFmt_t rFmt;
      iFmt_t iFmt;
   } instr_u;

   typedef enum logic [4:0] {
      OP_ADD = 5'b00100,
      OP_SUB = 5'b00101,
      OP_AND = 5'b00110,
      OP_OR  = 5'b00111,
      OP_SHL = 5'b01000,
      OP_SHR = 5'b01001,
      OP_MUL = 5'b01110
   } aluOp_t;

   // Index 0 has the highest bus priority
   typedef struct packed {
      logic [11:0]                    req;
      logic [11:0][`WORD_W-1:0]       data;
   } busReq_t;

endpackage

//--- hdl/datapath_params.svh
// Sizes for a 32-bit datapath; MEM_LATENCY must be at least 2 and MEM_DEPTH a power of two
`ifndef DATAPATH_PARAMS_SVH
`define DATAPATH_PARAMS_SVH

// Data word width, fixed at 32 by the instruction format
`define WORD_W 32

// General register count, addressed by 4-bit fields
`define REG_COUNT 16

// RAM words, addressed by the low bits of MAR
`define MEM_DEPTH 512

// Cycles from a Read or Write strobe to memFinished
`define MEM_LATENCY 2

`endif
